//--- Bender.yml
package:
  name: rv32i_cpu

sources:
  - source/rv32i_types.sv
  - source/cpu_control.sv
  - source/alu.sv
  - source/cmp.sv
  - source/regfile.sv
  - source/cpu_datapath.sv
  - source/cpu.sv
  - target: test
    files:
      - dv/cpu_props.sv
      - dv/tb_cpu.sv

//--- dv/cpu_props.sv
`timescale 1ns/10ps

module cpu_props (
	input logic clk,
	input logic rst_n,
	input logic read_a,
	input logic [31:0] address_a,
	input logic resp_a,
	input logic read_b,
	input logic write,
	input logic [3:0] wmask,
	input logic [31:0] address_b,
	input logic [31:0] wdata,
	input logic resp_b
);
	import rv32i_types::*;

	int violations = 0;

	fetch_stable: assert property (@(posedge clk) disable iff (!rst_n)
		read_a && !resp_a |=> read_a && $stable(address_a))
		else begin
			violations++;
			$error("fetch request changed while waiting for resp_a");
		end

	load_stable: assert property (@(posedge clk) disable iff (!rst_n)
		read_b && !resp_b |=> read_b && $stable(address_b))
		else begin
			violations++;
			$error("load request changed while waiting for resp_b");
		end

	store_stable: assert property (@(posedge clk) disable iff (!rst_n)
		write && !resp_b |=> write && $stable(address_b) && $stable(wdata))
		else begin
			violations++;
			$error("store request changed while waiting for resp_b");
		end

	mask_full: assert property (@(posedge clk) disable iff (!rst_n)
		write |-> wmask == 4'hf)
		else begin
			violations++;
			$error("wmask not all ones during a store");
		end

	// Held in reset and for the first cycle after it
	reset_idle: assert property (@(posedge clk)
		(!rst_n || $past(!rst_n)) |-> !read_b && !write && address_a == reset_pc)
		else begin
			violations++;
			$error("memory ports not idle around reset");
		end

endmodule

bind cpu cpu_props props_i (
	.clk(clk),
	.rst_n(rst_n),
	.read_a(read_a),
	.address_a(address_a),
	.resp_a(resp_a),
	.read_b(read_b),
	.write(write),
	.wmask(wmask),
	.address_b(address_b),
	.wdata(wdata),
	.resp_b(resp_b)
);

//--- dv/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;
	import rv32i_types::*;

	logic clk;
	logic rst_n;
	logic read_a;
	logic [31:0] address_a;
	logic [31:0] rdata_a;
	logic resp_a;
	logic read_b;
	logic write;
	logic [3:0] wmask;
	logic [31:0] address_b;
	logic [31:0] wdata;
	logic [31:0] rdata_b;
	logic resp_b;

	logic [31:0] prog [0:255];
	logic [31:0] dmem [0:1023];
	logic [31:0] exp_addr [0:31];
	logic [31:0] exp_data [0:31];
	logic [31:0] head_addr;
	logic [31:0] head_data;
	logic [31:0] lcg_state = 32'd88866;
	logic [31:0] loop_word;
	logic [31:0] here;
	logic busy_a = 1'b0;
	logic busy_b = 1'b0;
	int unsigned wait_a;
	int unsigned wait_b;
	int n_instr = 0;
	int n_exp = 0;
	int exp_idx = 0;
	int loop_seen = 0;

	cpu cpu_i (
		.clk(clk),
		.rst_n(rst_n),
		.read_a(read_a),
		.address_a(address_a),
		.rdata_a(rdata_a),
		.resp_a(resp_a),
		.read_b(read_b),
		.write(write),
		.wmask(wmask),
		.address_b(address_b),
		.wdata(wdata),
		.rdata_b(rdata_b),
		.resp_b(resp_b)
	);

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// Response delay of 1 to 4 cycles
	function automatic int unsigned next_delay();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[17:16]) + 1;
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[n_instr] = word;
		n_instr++;
	endtask

	// SW of rs2 to a result slot, with the value RV32I gives it
	task automatic store_result(input logic [4:0] rs2, input logic [11:0] addr,
		input logic [31:0] value);
		emit(s_type(addr, rs2, 5'd0));
		exp_addr[n_exp] = {20'd0, addr};
		exp_data[n_exp] = value;
		n_exp++;
	endtask

	initial begin
		clk = 1'b1;
		forever #10 clk = ~clk;
	end

	// Both memories answer on the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			resp_a <= 1'b0;
			resp_b <= 1'b0;
			busy_a = 1'b0;
			busy_b = 1'b0;
		end else begin
			if (resp_a) begin
				resp_a <= 1'b0;
			end else if (read_a) begin
				if (!busy_a) begin
					busy_a = 1'b1;
					wait_a = next_delay();
				end
				wait_a--;
				if (wait_a == 0) begin
					busy_a = 1'b0;
					resp_a <= 1'b1;
					rdata_a <= prog[address_a[9:2]];
				end
			end
			if (resp_b) begin
				resp_b <= 1'b0;
			end else if (read_b || write) begin
				if (!busy_b) begin
					busy_b = 1'b1;
					wait_b = next_delay();
				end
				wait_b--;
				if (wait_b == 0) begin
					busy_b = 1'b0;
					resp_b <= 1'b1;
					if (write) begin
						dmem[address_b[11:2]] = wdata;
					end else begin
						rdata_b <= dmem[address_b[11:2]];
					end
				end
			end
		end
	end

	assign head_addr = exp_addr[exp_idx];
	assign head_data = exp_data[exp_idx];

	always @(posedge clk) begin
		if (rst_n && write && resp_b) begin
			exp_idx <= exp_idx + 1;
		end
	end

	always @(posedge clk) begin
		if (rst_n && cpu_i.datapath.step && cpu_i.instr == loop_word) begin
			loop_seen <= loop_seen + 1;
		end
	end

	store_check: assert property (@(posedge clk) disable iff (!rst_n)
		(write && resp_b) |->
			(exp_idx < n_exp && address_b == head_addr && wdata == head_data))
		else begin
			$display("FAIL %0t: store of %h to %h, expected %h to %h", $time,
				$sampled(wdata), $sampled(address_b), $sampled(head_data),
				$sampled(head_addr));
			$display("TEST FAIL");
			$fatal(1, "store mismatch");
		end

	always @(posedge clk) begin
		if (cpu_i.props_i.violations != 0) begin
			$display("A memory port property of the core was violated");
			$display("TEST FAIL");
			$fatal(1, "memory port property violated");
		end
	end

	initial begin
		#1;
		repeat (n_instr * 4 * 4 + 200) @(posedge clk);
		$display("Timeout: the program did not finish in time");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_n = 1'b1;
		resp_a = 1'b0;
		resp_b = 1'b0;
		rdata_a = '0;
		rdata_b = '0;
		for (int i = 0; i < 256; i++) begin
			// addi x0, x0, index
			prog[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, op_imm);
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = 32'hbad0_0000 | 32'(i);
		end

		emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, op_imm));
		emit(i_type(12'hffd, 5'd0, 3'b000, 5'd2, op_imm));
		emit(r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd3));
		store_result(5'd3, 12'h100, 32'd2);
		emit(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
		store_result(5'd4, 12'h104, 32'd8);
		emit(i_type(12'd3, 5'd1, 3'b001, 5'd5, op_imm));
		store_result(5'd5, 12'h108, 32'h28);
		emit(i_type(12'h401, 5'd2, 3'b101, 5'd6, op_imm));
		store_result(5'd6, 12'h10c, 32'hffff_fffe);
		emit(i_type(12'd28, 5'd2, 3'b101, 5'd7, op_imm));
		store_result(5'd7, 12'h110, 32'h0000_000f);
		emit(r_type(7'd0, 5'd1, 5'd2, 3'b010, 5'd8));
		store_result(5'd8, 12'h114, 32'd1);
		emit(r_type(7'd0, 5'd1, 5'd2, 3'b011, 5'd9));
		store_result(5'd9, 12'h118, 32'd0);
		emit(i_type(12'h0ff, 5'd1, 3'b100, 5'd10, op_imm));
		store_result(5'd10, 12'h11c, 32'h0000_00fa);
		emit(r_type(7'd0, 5'd5, 5'd1, 3'b110, 5'd11));
		emit(r_type(7'd0, 5'd5, 5'd2, 3'b111, 5'd12));
		store_result(5'd11, 12'h120, 32'h2d);
		store_result(5'd12, 12'h124, 32'h28);
		emit(u_type(20'h12345, 5'd13, op_lui));
		store_result(5'd13, 12'h128, 32'h1234_5000);
		here = n_instr * 4;
		emit(u_type(20'h00001, 5'd14, op_auipc));
		store_result(5'd14, 12'h12c, here + 32'h1000);

		// Dependent chain, then the same chain spread out
		emit(i_type(12'd7, 5'd0, 3'b000, 5'd15, op_imm));
		emit(i_type(12'd1, 5'd15, 3'b000, 5'd15, op_imm));
		emit(r_type(7'd0, 5'd15, 5'd15, 3'b000, 5'd16));
		store_result(5'd16, 12'h130, 32'd16);
		emit(i_type(12'd7, 5'd0, 3'b000, 5'd17, op_imm));
		emit(nop_instr);
		emit(nop_instr);
		emit(i_type(12'd1, 5'd17, 3'b000, 5'd17, op_imm));
		emit(nop_instr);
		emit(nop_instr);
		emit(r_type(7'd0, 5'd17, 5'd17, 3'b000, 5'd18));
		emit(nop_instr);
		store_result(5'd18, 12'h134, 32'd16);

		// Load followed at once by a use
		emit(i_type(12'h055, 5'd0, 3'b000, 5'd19, op_imm));
		store_result(5'd19, 12'h200, 32'h55);
		emit(i_type(12'h200, 5'd0, 3'b010, 5'd20, op_load));
		emit(i_type(12'd3, 5'd20, 3'b000, 5'd21, op_imm));
		store_result(5'd21, 12'h138, 32'h58);
		emit(i_type(12'h138, 5'd0, 3'b010, 5'd22, op_load));
		store_result(5'd22, 12'h13c, 32'h58);

		// Skipped stores carry wrong markers
		emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));
		emit(s_type(12'h140, 5'd2, 5'd0));
		emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));
		store_result(5'd1, 12'h140, 32'd5);
		emit(b_type(13'd8, 5'd1, 5'd2, 3'b100));
		emit(s_type(12'h144, 5'd2, 5'd0));
		emit(b_type(13'd8, 5'd1, 5'd2, 3'b110));
		store_result(5'd5, 12'h144, 32'h28);
		emit(b_type(13'd8, 5'd2, 5'd1, 3'b101));
		emit(s_type(12'h148, 5'd2, 5'd0));
		emit(b_type(13'd8, 5'd1, 5'd2, 3'b111));
		emit(s_type(12'h148, 5'd2, 5'd0));
		here = n_instr * 4;
		emit(j_type(21'd8, 5'd23));
		emit(s_type(12'h148, 5'd2, 5'd0));
		store_result(5'd23, 12'h148, here + 32'd4);
		// JALR lands two words past itself
		here = (n_instr + 1) * 4;
		emit(i_type(here[11:0] + 12'd8, 5'd0, 3'b000, 5'd24, op_imm));
		emit(i_type(12'd0, 5'd24, 3'b000, 5'd25, op_jalr));
		emit(s_type(12'h14c, 5'd2, 5'd0));
		store_result(5'd25, 12'h14c, here + 32'd4);
		loop_word = j_type(21'd0, 5'd0);
		emit(loop_word);

		@(negedge clk);
		rst_n <= 1'b0;
		repeat (2) @(negedge clk);
		rst_n <= 1'b1;

		// Second pass through the self-loop means all earlier work retired
		wait (loop_seen >= 2);
		@(negedge clk);
		if (exp_idx == n_exp) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("Only %0d of %0d expected stores were seen", exp_idx, n_exp);
			$display("TEST FAIL");
			$fatal(1, "stores missing");
		end
	end

endmodule

//--- source/alu.sv
`timescale 1ns/10ps

module alu (
	input rv32i_types::alu_ops aluop,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] f
);
	import rv32i_types::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (aluop)
			alu_add: f = a + b;
			alu_sub: f = a - b;
			alu_sll: f = a << shamt;
			alu_slt: f = {31'd0, $signed(a) < $signed(b)};
			alu_sltu: f = {31'd0, a < b};
			alu_xor: f = a ^ b;
			alu_srl: f = a >> shamt;
			alu_sra: f = $unsigned($signed(a) >>> shamt);
			alu_or: f = a | b;
			alu_and: f = a & b;
			default: f = a + b;
		endcase
	end

endmodule

//--- source/cmp.sv
`timescale 1ns/10ps

module cmp (
	input rv32i_types::branch_funct3 cmpop,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic br_en
);
	import rv32i_types::*;

	always_comb begin
		case (cmpop)
			beq: br_en = a == b;
			bne: br_en = a != b;
			blt: br_en = $signed(a) < $signed(b);
			bge: br_en = $signed(a) >= $signed(b);
			bltu: br_en = a < b;
			bgeu: br_en = a >= b;
			// Reserved funct3 values never branch
			default: br_en = 1'b0;
		endcase
	end

endmodule

//--- source/cpu.sv
`timescale 1ns/10ps

module cpu (
	input logic clk,
	input logic rst_n,
	output logic read_a,
	output logic [31:0] address_a,
	input logic [31:0] rdata_a,
	input logic resp_a,
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output logic [31:0] address_b,
	output logic [31:0] wdata,
	input logic [31:0] rdata_b,
	input logic resp_b
);
	import rv32i_types::*;

	logic [31:0] instr;
	rv32i_control_word cword;

	cpu_control ctrl (
		.instr(instr),
		.cword(cword)
	);

	cpu_datapath datapath (
		.clk(clk),
		.rst_n(rst_n),
		.resp_a(resp_a),
		.resp_b(resp_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.cword(cword),
		.instr(instr),
		.read_a(read_a),
		.read_b(read_b),
		.write(write),
		.wmask(wmask),
		.address_a(address_a),
		.address_b(address_b),
		.wdata(wdata)
	);

endmodule

//--- source/cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
	input logic [31:0] instr,
	output rv32i_types::rv32i_control_word cword
);
	import rv32i_types::*;

	rv32i_opcode opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
	logic shift_r;

	assign opcode = rv32i_opcode'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign shift_r = (funct3 == 3'b101);

	assign i_imm = {{21{instr[31]}}, instr[30:20]};
	assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'h000};
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		cword = '0;
		cword.aluop = alu_add;
		cword.cmpop = branch_funct3'(funct3);
		cword.alumux1_sel = mux1_rs1;
		cword.alumux2_sel = mux2_imm;
		cword.imm = i_imm;
		cword.wbmux_sel = wb_alu;
		// Unused source fields stay x0 so they never forward or stall
		case (opcode)
			op_lui, op_auipc: begin
				cword.alumux1_sel = (opcode == op_auipc) ? mux1_pc : mux1_rs1;
				cword.imm = u_imm;
				cword.rd = instr[11:7];
				cword.load_regfile = 1'b1;
			end
			op_jal, op_jalr: begin
				cword.alumux1_sel = (opcode == op_jal) ? mux1_pc : mux1_rs1;
				cword.imm = (opcode == op_jal) ? j_imm : i_imm;
				cword.rs1 = (opcode == op_jal) ? 5'd0 : instr[19:15];
				cword.rd = instr[11:7];
				cword.load_regfile = 1'b1;
				cword.jump = 1'b1;
				cword.wbmux_sel = wb_pc4;
			end
			op_br: begin
				cword.alumux1_sel = mux1_pc;
				cword.imm = b_imm;
				cword.rs1 = instr[19:15];
				cword.rs2 = instr[24:20];
				cword.branch = 1'b1;
			end
			op_load: begin
				cword.rs1 = instr[19:15];
				cword.rd = instr[11:7];
				cword.load_regfile = funct3 == 3'b010;
				cword.mem_read = funct3 == 3'b010;
				cword.wbmux_sel = wb_load;
			end
			op_store: begin
				cword.imm = s_imm;
				cword.rs1 = instr[19:15];
				cword.rs2 = instr[24:20];
				cword.mem_write = funct3 == 3'b010;
			end
			op_imm: begin
				cword.aluop = alu_ops'({shift_r & funct7[5], funct3});
				cword.rs1 = instr[19:15];
				cword.rd = instr[11:7];
				cword.load_regfile = 1'b1;
			end
			op_reg: begin
				cword.aluop = alu_ops'({(shift_r | funct3 == 3'b000) & funct7[5], funct3});
				cword.alumux2_sel = mux2_rs2;
				cword.rs1 = instr[19:15];
				cword.rs2 = instr[24:20];
				cword.rd = instr[11:7];
				// M extension encodings fall through as no-ops
				cword.load_regfile = (funct7 & 7'b1011111) == 7'd0;
			end
			default: ;
		endcase
	end

endmodule

//--- source/cpu_datapath.sv
`timescale 1ns/10ps

module cpu_datapath (
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input logic resp_b,
	input logic [31:0] rdata_a,
	input logic [31:0] rdata_b,
	input rv32i_types::rv32i_control_word cword,
	output logic [31:0] instr,
	output logic read_a,
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output logic [31:0] address_a,
	output logic [31:0] address_b,
	output logic [31:0] wdata
);
	import rv32i_types::*;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [31:0] instr;
	} ex_reg_t;

	typedef struct packed {
		logic [xlen-1:0] alu_out;
		logic [xlen-1:0] store_data;
		logic [xlen-1:0] pc_plus4;
	} mw_data_t;

	logic [xlen-1:0] pc;
	ex_reg_t ex_q;
	rv32i_control_word mw_cw;
	mw_data_t mw_q;
	logic mw_done;
	logic [xlen-1:0] ld_buf;

	logic [xlen-1:0] rs1_data, rs2_data, fwd_rs1, fwd_rs2;
	logic [xlen-1:0] alu_a, alu_b, alu_out, target, load_data, wb_data;
	logic br_en, redirect, load_use, fwd1, fwd2;
	logic mw_mem, mem_ok, step;

	assign instr = ex_q.instr;

	// IF
	assign read_a = 1'b1;
	assign address_a = pc;

	// Port b drops its request once the response has been taken
	assign mw_mem = mw_cw.mem_read | mw_cw.mem_write;
	assign read_b = mw_cw.mem_read & ~mw_done;
	assign write = mw_cw.mem_write & ~mw_done;
	assign wmask = {4{write}};
	assign address_b = mw_q.alu_out;
	assign wdata = mw_q.store_data;

	// Advance only when the fetch and any MW access are both complete
	assign mem_ok = ~mw_mem | resp_b | mw_done;
	assign step = resp_a & mem_ok;

	assign load_use = mw_cw.mem_read && (mw_cw.rd != 5'd0) &&
		(mw_cw.rd == cword.rs1 || mw_cw.rd == cword.rs2);

	regfile rf (
		.clk(clk),
		.rst_n(rst_n),
		.load(mw_cw.load_regfile & step),
		.in(wb_data),
		.src_a(cword.rs1),
		.src_b(cword.rs2),
		.dest(mw_cw.rd),
		.reg_a(rs1_data),
		.reg_b(rs2_data)
	);

	// EX operands, MW result forwarded
	assign fwd1 = mw_cw.load_regfile && (mw_cw.rd != 5'd0) && (mw_cw.rd == cword.rs1);
	assign fwd2 = mw_cw.load_regfile && (mw_cw.rd != 5'd0) && (mw_cw.rd == cword.rs2);
	assign fwd_rs1 = fwd1 ? wb_data : rs1_data;
	assign fwd_rs2 = fwd2 ? wb_data : rs2_data;
	assign alu_a = (cword.alumux1_sel == mux1_pc) ? ex_q.pc : fwd_rs1;
	assign alu_b = (cword.alumux2_sel == mux2_rs2) ? fwd_rs2 : cword.imm;

	alu alu_i (
		.aluop(cword.aluop),
		.a(alu_a),
		.b(alu_b),
		.f(alu_out)
	);

	cmp cmp_i (
		.cmpop(cword.cmpop),
		.a(fwd_rs1),
		.b(fwd_rs2),
		.br_en(br_en)
	);

	// JALR needs bit 0 cleared, other targets are already even
	assign target = {alu_out[xlen-1:1], 1'b0};
	assign redirect = (cword.jump | (cword.branch & br_en)) & ~load_use;

	// MW and write-back
	assign load_data = mw_done ? ld_buf : rdata_b;

	always_comb begin
		case (mw_cw.wbmux_sel)
			wb_pc4: wb_data = mw_q.pc_plus4;
			wb_load: wb_data = load_data;
			default: wb_data = mw_q.alu_out;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= reset_pc;
			ex_q <= '{pc: reset_pc, instr: nop_instr};
			mw_cw <= '0;
			mw_done <= 1'b0;
		end else if (step) begin
			mw_done <= 1'b0;
			if (load_use) begin
				// Bubble into MW, EX waits for the loaded value
				mw_cw <= '0;
			end else begin
				mw_cw <= cword;
				pc <= redirect ? target : pc + 32'd4;
				ex_q.pc <= pc;
				ex_q.instr <= redirect ? nop_instr : rdata_a;
			end
		end else if (resp_b & mw_mem) begin
			mw_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (step & ~load_use) begin
			mw_q.alu_out <= alu_out;
			mw_q.store_data <= fwd_rs2;
			mw_q.pc_plus4 <= ex_q.pc + 32'd4;
		end
		if (resp_b & read_b) begin
			ld_buf <= rdata_b;
		end
	end

endmodule

//--- source/regfile.sv
`timescale 1ns/10ps

module regfile (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic [31:0] in,
	input logic [4:0] src_a,
	input logic [4:0] src_b,
	input logic [4:0] dest,
	output logic [31:0] reg_a,
	output logic [31:0] reg_b
);
	logic [31:0] regs [0:31];
	logic wr_en;

	assign wr_en = load && (dest != 5'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[dest] <= in;
		end
	end

	// Same-cycle write bypass
	assign reg_a = (wr_en && src_a == dest) ? in : regs[src_a];
	assign reg_b = (wr_en && src_b == dest) ? in : regs[src_b];

endmodule

//--- source/rv32i_types.sv
package rv32i_types;

	localparam int xlen = 32;
	localparam logic [31:0] nop_instr = 32'h0000_0013;
	localparam logic [31:0] reset_pc = 32'h0000_0000;

	// Operand select encodings
	localparam logic mux1_rs1 = 1'b0;
	localparam logic mux1_pc = 1'b1;
	localparam logic mux2_imm = 1'b0;
	localparam logic mux2_rs2 = 1'b1;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	// Encoded as {funct7[5], funct3}
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_ops;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3;

	typedef enum logic [1:0] {
		wb_alu  = 2'b00,
		wb_pc4  = 2'b01,
		wb_load = 2'b10
	} wb_sel;

	typedef struct packed {
		alu_ops aluop;
		branch_funct3 cmpop;
		logic alumux1_sel;
		logic alumux2_sel;
		logic [xlen-1:0] imm;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic load_regfile;
		logic mem_read;
		logic mem_write;
		logic branch;
		logic jump;
		wb_sel wbmux_sel;
	} rv32i_control_word;

endpackage

//--- tb.f
source/rv32i_types.sv
source/cpu_control.sv
source/alu.sv
source/cmp.sv
source/regfile.sv
source/cpu_datapath.sv
source/cpu.sv
dv/cpu_props.sv
dv/tb_cpu.sv
